//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pw_conv
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
verilog/mbconv_pkg.sv
verilog/pe_bus_if.sv
verilog/pw_feeder.sv
verilog/pe_mac.sv
verilog/ofm_collector.sv
verilog/pw_conv_top.sv
sim/tb_pw_conv.sv

//--- sim/tb_pw_conv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pw_conv
    import mbconv_pkg::*;
;

    localparam int PIX2    = 20;
    localparam int WORDS2  = 3;
    localparam int FRAME_N = PIX2 * WORDS2;

    // reset, two single-pixel tests, the random load, two full frames with readback
    localparam int SINGLE_LEN     = (N_PE + 1) + (1 + 3 + 6) + 1;
    localparam int FRAME_LEN      = (FRAME_N + 3 + 6) + PIX2;
    localparam int LOAD_LEN       = N_PE * WORDS2 + FRAME_N;
    localparam int TIMEOUT_CYCLES = 9 + 2 * SINGLE_LEN + LOAD_LEN + 2 * FRAME_LEN + 200;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  run;
    logic [CFG_PIX_W-1:0]  cfg_pixels;
    logic [CFG_WORD_W-1:0] cfg_words;
    logic                  ifm_wr_en;
    logic [IFM_AW-1:0]     ifm_wr_addr;
    logic [WORD_W-1:0]     ifm_wr_data;
    logic                  wt_wr_en;
    logic [1:0]            wt_wr_pe;
    logic [WT_AW-1:0]      wt_wr_addr;
    logic [WORD_W-1:0]     wt_wr_data;
    logic [OFM_AW-1:0]     ofm_rd_addr;
    wire                   busy;
    wire                   done;
    wire  [WORD_W-1:0]     ofm_rd_data;

    // host-side copies of the buffers
    logic [WORD_W-1:0] ifm_model [2**IFM_AW];
    logic [WORD_W-1:0] wt_model [N_PE][2**WT_AW];

    int mismatch_count = 0;
    int fail_count     = 0;
    int done_count     = 0;
    int cycle_count    = 0;

    pw_conv_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .cfg_pixels  (cfg_pixels),
        .cfg_words   (cfg_words),
        .ifm_wr_en   (ifm_wr_en),
        .ifm_wr_addr (ifm_wr_addr),
        .ifm_wr_data (ifm_wr_data),
        .wt_wr_en    (wt_wr_en),
        .wt_wr_pe    (wt_wr_pe),
        .wt_wr_addr  (wt_wr_addr),
        .wt_wr_data  (wt_wr_data),
        .ofm_rd_addr (ofm_rd_addr),
        .busy        (busy),
        .done        (done),
        .ofm_rd_data (ofm_rd_data)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $display("done stayed high for more than one cycle");
        end

    a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else begin
            fail_count++;
            $display("done pulsed while busy was low");
        end

    function automatic int lane_of(input logic [WORD_W-1:0] w, input int i);
        return int'($signed(w[i*DATA_W +: DATA_W]));
    endfunction

    // dot product per element, then shift, clamp below at 0 and above at 127
    function automatic logic [WORD_W-1:0] expected_word(input int pix, input int words);
        logic [WORD_W-1:0] packed_w;
        int sum;
        int q;
        packed_w = '0;
        for (int k = 0; k < N_PE; k++) begin
            sum = 0;
            for (int w = 0; w < words; w++) begin
                for (int i = 0; i < LANES; i++) begin
                    sum += lane_of(ifm_model[IFM_AW'(pix * words + w)], i) *
                           lane_of(wt_model[2'(k)][WT_AW'(w)], i);
                end
            end
            q = sum >>> REQUANT_SHIFT;
            if (q < 0) q = 0;
            if (q > 127) q = 127;
            packed_w[k*DATA_W +: DATA_W] = q[DATA_W-1:0];
        end
        return packed_w;
    endfunction

    task automatic write_ifm(input int addr, input logic [WORD_W-1:0] data);
        ifm_wr_en   = 1'b1;
        ifm_wr_addr = IFM_AW'(addr);
        ifm_wr_data = data;
        ifm_model[IFM_AW'(addr)] = data;
        @(negedge clk);
        ifm_wr_en = 1'b0;
    endtask

    task automatic write_wt(input int pe, input int addr, input logic [WORD_W-1:0] data);
        wt_wr_en   = 1'b1;
        wt_wr_pe   = 2'(pe);
        wt_wr_addr = WT_AW'(addr);
        wt_wr_data = data;
        wt_model[2'(pe)][WT_AW'(addr)] = data;
        @(negedge clk);
        wt_wr_en = 1'b0;
    endtask

    // pulse run, optionally poke the host ports mid-frame, time the done pulse
    task automatic run_frame(input int pixels, input int words, input bit inject);
        int cyc;
        int limit;
        int dones;
        limit      = pixels * words + 3;
        dones      = done_count;
        cfg_pixels = CFG_PIX_W'(pixels);
        cfg_words  = CFG_WORD_W'(words);
        run        = 1'b1;
        @(negedge clk);
        cyc = 0;
        while (!done && cyc <= limit) begin
            a_busy_frame: assert (busy) else begin
                fail_count++;
                $display("busy was low in cycle %0d of the frame", cyc);
            end
            run       = inject && (cyc == 2);
            ifm_wr_en = run;
            wt_wr_en  = run;
            if (run) begin
                ifm_wr_addr = IFM_AW'($urandom_range(pixels * words - 1));
                ifm_wr_data = $urandom;
                wt_wr_pe    = 2'($urandom_range(N_PE - 1));
                wt_wr_addr  = WT_AW'($urandom_range(words - 1));
                wt_wr_data  = $urandom;
            end
            @(negedge clk);
            cyc++;
        end
        run       = 1'b0;
        ifm_wr_en = 1'b0;
        wt_wr_en  = 1'b0;
        a_done_seen: assert (done) else begin
            fail_count++;
            $display("done did not arrive within %0d cycles of run", limit);
        end
        a_done_time: assert (cyc == limit) else begin
            mismatch_count++;
            $display("Mismatch at %0t: done in cycle %0d after run, expected %0d",
                     $time, cyc, limit);
        end
        @(negedge clk);
        a_idle_after: assert (!busy && !done) else begin
            fail_count++;
            $display("busy or done still high after the done cycle");
        end
        repeat (4) @(negedge clk);
        a_one_done: assert (done_count == dones + 1) else begin
            fail_count++;
            $display("expected one done pulse for the run, saw %0d", done_count - dones);
        end
    endtask

    task automatic check_frame(input int pixels, input int words);
        logic [WORD_W-1:0] exp_word;
        for (int p = 0; p < pixels; p++) begin
            ofm_rd_addr = OFM_AW'(p);
            @(negedge clk);
            exp_word = expected_word(p, words);
            a_ofm_word: assert (ofm_rd_data == exp_word) else begin
                mismatch_count++;
                $display("Mismatch at %0t: pixel %0d read %h, expected %h",
                         $time, p, ofm_rd_data, exp_word);
            end
        end
    endtask

    initial begin : main
        void'($urandom(32'h1d76_fbd1));
        rst_n       = 1'b0;
        run         = 1'b0;
        cfg_pixels  = '0;
        cfg_words   = '0;
        ifm_wr_en   = 1'b0;
        ifm_wr_addr = '0;
        ifm_wr_data = '0;
        wt_wr_en    = 1'b0;
        wt_wr_pe    = '0;
        wt_wr_addr  = '0;
        wt_wr_data  = '0;
        ofm_rd_addr = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        a_reset_idle: assert (!busy && !done) else begin
            fail_count++;
            $display("busy or done high right after reset");
        end

        // single hand-picked pixel
        write_ifm(0, 32'h28EC_1E0A);
        write_wt(0, 0, 32'h2010_407F);
        write_wt(1, 0, 32'h0102_0304);
        write_wt(2, 0, 32'h7F7F_7F7F);
        write_wt(3, 0, 32'h8000_0000);
        run_frame(1, 1, 1'b0);
        check_frame(1, 1);

        // random frame, then the same frame with host traffic while busy
        for (int w = 0; w < WORDS2; w++) begin
            for (int k = 0; k < N_PE; k++) begin
                write_wt(k, w, $urandom);
            end
        end
        for (int a = 0; a < FRAME_N; a++) begin
            write_ifm(a, $urandom);
        end
        run_frame(PIX2, WORDS2, 1'b0);
        check_frame(PIX2, WORDS2);
        run_frame(PIX2, WORDS2, 1'b1);
        check_frame(PIX2, WORDS2);

        // saturation at both ends
        write_ifm(0, 32'h7F7F_7F7F);
        write_wt(0, 0, 32'h7F7F_7F7F);
        write_wt(1, 0, 32'h8080_8080);
        write_wt(2, 0, 32'h4040_4040);
        write_wt(3, 0, 32'h8181_8181);
        run_frame(1, 1, 1'b0);
        check_frame(1, 1);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count + fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mbconv_pkg.sv
`default_nettype none

package mbconv_pkg;

    // lane and word geometry
    localparam int LANES  = 4;
    localparam int DATA_W = 8;
    localparam int WORD_W = 32;

    // one processing element per output channel
    localparam int N_PE = 4;

    // buffer address widths
    localparam int IFM_AW = 8;
    localparam int WT_AW  = 4;
    localparam int OFM_AW = 6;

    // accumulator and requantization
    localparam int ACC_W         = 24;
    localparam int REQUANT_SHIFT = 7;

    // host config field widths
    localparam int CFG_PIX_W  = 7;
    localparam int CFG_WORD_W = 5;

    // cycles from last buffer read to end of done (pe stage, result, done)
    localparam logic [1:0] PIPE_DRAIN = 2'd3;

    typedef logic signed [DATA_W-1:0] lane_t;

    // lane 0 sits in the low byte
    typedef union packed {
        logic [WORD_W-1:0] raw;
        lane_t [LANES-1:0] lanes;
    } word_u;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic [$clog2(N_PE)-1:0] pe_idx_t;

    localparam acc_t LANE_MAX = acc_t'(2 ** (DATA_W - 1) - 1);

    // shift, relu, then saturate to the int8 top
    function automatic lane_t requantize(input acc_t acc);
        acc_t shifted;
        shifted = acc >>> REQUANT_SHIFT;
        if (shifted < 0) begin
            return '0;
        end
        if (shifted > LANE_MAX) begin
            return LANE_MAX[DATA_W-1:0];
        end
        return shifted[DATA_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- verilog/ofm_collector.sv
`timescale 1ns/1ps
`default_nettype none

module ofm_collector
    import mbconv_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire lane_t [N_PE-1:0]   result,
    input  wire [N_PE-1:0]          result_valid,
    input  wire [N_PE-1:0]          result_last,
    input  wire [OFM_AW-1:0]        ofm_rd_addr,
    output word_u                   ofm_rd_data,
    output logic                    done
);

    logic [WORD_W-1:0] ofm_mem [2**OFM_AW];
    word_u             wr_word;
    logic [OFM_AW-1:0] pix_cnt;
    logic              wr_en;
    logic              wr_last;

    // all elements move in lockstep, bit 0 speaks for the array
    assign wr_en   = result_valid[0];
    assign wr_last = result_last[0];

    // element k lands in lane k
    always_comb begin
        wr_word = '0;
        for (int k = 0; k < N_PE; k++) begin
            wr_word.lanes[k] = result[k];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ofm_mem[pix_cnt] <= wr_word.raw;
        end
        ofm_rd_data.raw <= ofm_mem[ofm_rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= wr_en && wr_last;
            if (wr_en) begin
                // next frame starts at pixel 0
                if (wr_last) begin
                    pix_cnt <= '0;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    a_pe_lockstep: assert property (@(posedge clk) disable iff (!rst_n)
        ((result_valid == '0) || (result_valid == '1)) &&
        ((result_last == '0) || (result_last == '1)))
        else $error("processing elements disagree on result timing");

endmodule

`default_nettype wire

//--- verilog/pe_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pe_bus_if
    import mbconv_pkg::*;
;

    // pixel stream, one word per cycle, no back-pressure
    logic              valid;
    word_u             ifm;
    logic [WT_AW-1:0]  wt_addr;
    logic              first;
    logic              last;
    logic              frame_end;

    // host weight load, enable already decoded per element
    logic [N_PE-1:0]   wt_we;
    logic [WT_AW-1:0]  wt_wr_addr;
    word_u             wt_wr_data;

    modport feeder (
        output valid, ifm, wt_addr, first, last, frame_end,
        output wt_we, wt_wr_addr, wt_wr_data
    );

    // bank enable reaches each element through its own slice of wt_we
    modport pe (
        input valid, ifm, wt_addr, first, last, frame_end,
        input wt_wr_addr, wt_wr_data
    );

endinterface

`default_nettype wire

//--- verilog/pe_mac.sv
`timescale 1ns/1ps
`default_nettype none

module pe_mac
    import mbconv_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    pe_bus_if.pe        bus,
    input  wire         bank_we,
    output lane_t       result,
    output logic        result_valid,
    output logic        result_last
);

    logic [WORD_W-1:0]    wt_mem [2**WT_AW];
    word_u                wt_q;
    word_u                s_ifm;
    logic                 s_valid;
    logic                 s_first;
    logic                 s_last;
    logic                 s_end;
    acc_t                 acc;
    acc_t                 acc_base;
    acc_t                 dot;
    logic signed [ACC_W:0] acc_wide;
    acc_t                 acc_next;

    // weight bank, read in step with the incoming word
    always_ff @(posedge clk) begin
        if (bank_we) begin
            wt_mem[bus.wt_wr_addr] <= bus.wt_wr_data.raw;
        end
        wt_q.raw <= wt_mem[bus.wt_addr];
    end

    // input word waits one cycle for its weight
    always_ff @(posedge clk) begin
        s_ifm <= bus.ifm;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
            s_first <= 1'b0;
            s_last  <= 1'b0;
            s_end   <= 1'b0;
        end else begin
            s_valid <= bus.valid;
            s_first <= bus.first;
            s_last  <= bus.last;
            s_end   <= bus.frame_end;
        end
    end

    // four signed lane products
    always_comb begin
        dot = '0;
        for (int i = 0; i < LANES; i++) begin
            dot = dot + acc_t'(s_ifm.lanes[i]) * acc_t'(wt_q.lanes[i]);
        end
    end

    assign acc_base = s_first ? '0 : acc;
    // one guard bit to catch wrap
    assign acc_wide = (ACC_W + 1)'(acc_base) + (ACC_W + 1)'(dot);
    assign acc_next = acc_wide[ACC_W-1:0];

    always_ff @(posedge clk) begin
        if (s_valid) begin
            acc <= acc_next;
        end
        if (s_valid && s_last) begin
            result <= requantize(acc_next);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_last  <= 1'b0;
        end else begin
            result_valid <= s_valid && s_last;
            result_last  <= s_valid && s_end;
        end
    end

    a_acc_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        s_valid |-> (acc_wide[ACC_W] == acc_wide[ACC_W-1]))
        else $error("accumulator overflowed its width");

endmodule

`default_nettype wire

//--- verilog/pw_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module pw_conv_top
    import mbconv_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    run,
    input  wire [CFG_PIX_W-1:0]    cfg_pixels,
    input  wire [CFG_WORD_W-1:0]   cfg_words,
    input  wire                    ifm_wr_en,
    input  wire [IFM_AW-1:0]       ifm_wr_addr,
    input  wire [WORD_W-1:0]       ifm_wr_data,
    input  wire                    wt_wr_en,
    input  wire [1:0]              wt_wr_pe,
    input  wire [WT_AW-1:0]        wt_wr_addr,
    input  wire [WORD_W-1:0]       wt_wr_data,
    input  wire [OFM_AW-1:0]       ofm_rd_addr,
    output logic                   busy,
    output logic                   done,
    output logic [WORD_W-1:0]      ofm_rd_data
);

    lane_t [N_PE-1:0] pe_result;
    logic  [N_PE-1:0] pe_valid;
    logic  [N_PE-1:0] pe_last;

    pe_bus_if pe_bus ();

    pw_feeder u_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .cfg_pixels  (cfg_pixels),
        .cfg_words   (cfg_words),
        .ifm_wr_en   (ifm_wr_en),
        .ifm_wr_addr (ifm_wr_addr),
        .ifm_wr_data (ifm_wr_data),
        .wt_wr_en    (wt_wr_en),
        .wt_wr_pe    (wt_wr_pe),
        .wt_wr_addr  (wt_wr_addr),
        .wt_wr_data  (wt_wr_data),
        .busy        (busy),
        .bus         (pe_bus.feeder)
    );

    // one element per output channel
    for (genvar g = 0; g < N_PE; g++) begin : g_pe
        pe_mac u_pe (
            .clk          (clk),
            .rst_n        (rst_n),
            .bus          (pe_bus.pe),
            .bank_we      (pe_bus.wt_we[g]),
            .result       (pe_result[g]),
            .result_valid (pe_valid[g]),
            .result_last  (pe_last[g])
        );
    end

    ofm_collector u_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (pe_result),
        .result_valid (pe_valid),
        .result_last  (pe_last),
        .ofm_rd_addr  (ofm_rd_addr),
        .ofm_rd_data  (ofm_rd_data),
        .done         (done)
    );

endmodule

`default_nettype wire

//--- verilog/pw_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module pw_feeder
    import mbconv_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    run,
    input  wire [CFG_PIX_W-1:0]    cfg_pixels,
    input  wire [CFG_WORD_W-1:0]   cfg_words,
    input  wire                    ifm_wr_en,
    input  wire [IFM_AW-1:0]       ifm_wr_addr,
    input  wire word_u             ifm_wr_data,
    input  wire                    wt_wr_en,
    input  wire pe_idx_t           wt_wr_pe,
    input  wire [WT_AW-1:0]        wt_wr_addr,
    input  wire word_u             wt_wr_data,
    output logic                   busy,
    pe_bus_if.feeder               bus
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STREAM,
        S_DRAIN
    } state_t;

    state_t                          state;
    logic [CFG_PIX_W-1:0]            pix_cnt;
    logic [CFG_PIX_W-1:0]            pix_lim;
    logic [CFG_WORD_W-1:0]           word_cnt;
    logic [CFG_WORD_W-1:0]           word_lim;
    logic [1:0]                      drain_cnt;
    logic [CFG_PIX_W+CFG_WORD_W-1:0] lin_addr;
    logic [IFM_AW-1:0]               rd_addr;
    logic                            streaming;
    logic                            word_end;
    logic                            pix_end;
    logic [WORD_W-1:0]               ifm_mem [2**IFM_AW];

    assign busy      = (state != S_IDLE);
    assign streaming = (state == S_STREAM);
    assign word_end  = (word_cnt == word_lim - 1'b1);
    assign pix_end   = (pix_cnt == pix_lim - 1'b1);

    // pixel-major layout, words of one pixel are contiguous
    assign lin_addr = pix_cnt * word_lim + word_cnt;
    assign rd_addr  = lin_addr[IFM_AW-1:0];

    // host loads only land while idle
    always_ff @(posedge clk) begin
        if (ifm_wr_en && !busy) begin
            ifm_mem[ifm_wr_addr] <= ifm_wr_data.raw;
        end
        bus.ifm.raw <= ifm_mem[rd_addr];
    end

    always_comb begin
        bus.wt_we = '0;
        if (wt_wr_en && !busy) begin
            bus.wt_we[wt_wr_pe] = 1'b1;
        end
    end

    assign bus.wt_wr_addr = wt_wr_addr;
    assign bus.wt_wr_data = wt_wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            pix_cnt   <= '0;
            pix_lim   <= '0;
            word_cnt  <= '0;
            word_lim  <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (run) begin
                        pix_lim  <= cfg_pixels;
                        word_lim <= cfg_words;
                        pix_cnt  <= '0;
                        word_cnt <= '0;
                        state    <= S_STREAM;
                    end
                end
                S_STREAM: begin
                    if (word_end) begin
                        word_cnt <= '0;
                        if (pix_end) begin
                            pix_cnt   <= '0;
                            drain_cnt <= PIPE_DRAIN;
                            state     <= S_DRAIN;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    // hold busy until the collector has pulsed done
                    if (drain_cnt == '0) begin
                        state <= S_IDLE;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // flags line up with the buffer's one-cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.valid     <= 1'b0;
            bus.first     <= 1'b0;
            bus.last      <= 1'b0;
            bus.frame_end <= 1'b0;
            bus.wt_addr   <= '0;
        end else begin
            bus.valid     <= streaming;
            bus.first     <= streaming && (word_cnt == '0);
            bus.last      <= streaming && word_end;
            bus.frame_end <= streaming && word_end && pix_end;
            bus.wt_addr   <= word_cnt[WT_AW-1:0];
        end
    end

    a_words_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (run && !busy) |-> (cfg_words != '0))
        else $error("run accepted with zero words per pixel");

    a_flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.first || bus.last || bus.frame_end) |-> bus.valid)
        else $error("stream marker raised without valid");

endmodule

`default_nettype wire
